/* project.f */
verilog/snes_ctrl_pkg.sv
verilog/core_settings_regs.sv
verilog/stick_deadzone.sv
verilog/rtc_packer.sv
verilog/save_slot_tracker.sv
verilog/snes_ctrl_top.sv
bench/tb_snes_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the control plane testbench with Verilator, run it into a log,
# and decide pass or fail from the log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_snes_ctrl -f project.f \
  && ./obj_dir/Vtb_snes_ctrl > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -qx "Test passed" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* bench/tb_snes_ctrl.sv */
// Control plane testbench
// drives bridge writes, stick samples, RTC time and data slot events
// into the top level and checks every block with assertions

`timescale 1ns/100ps

module tb_snes_ctrl
  import snes_ctrl_pkg::*;
();

  localparam int half_period = 20;
  localparam int drive_delay = 2;
  // tests take about 900 cycles and soft reset alone is over 600
  localparam int max_cycles  = 2000;

  logic                     clk_74a;
  logic                     pll_core_locked;
  logic [bridge_addr_w-1:0] bridge_addr;
  logic                     bridge_wr;
  logic [bridge_data_w-1:0] bridge_wr_data;
  logic [31:0]              cont1_joy;
  logic [31:0]              rtc_date;
  logic [31:0]              rtc_time;
  logic                     dataslot_requestread;
  logic                     dataslot_requestwrite;
  logic                     dataslot_allcomplete;
  logic [sram_size_w-1:0]   sram_size;
  logic                     ioctl_download;
  logic [rom_size_w-1:0]    rom_size;
  logic [rom_type_w-1:0]    rom_type;
  logic [ram_size_w-1:0]    ram_size;
  logic                     pal;
  logic                     forced_pal;
  logic                     cpu_turbo;
  logic                     gsu_turbo;
  logic                     multitap;
  logic                     lightgun;
  logic                     lightgun_type;
  logic                     mouse;
  logic [axis_w-1:0]        dpad_aim_speed;
  logic [axis_w-1:0]        joystick_deadzone;
  logic                     square_pixels;
  logic                     blend;
  logic [region_w-1:0]      core_region;
  logic                     reset_button;
  logic [axis_w-1:0]        stick_x_cal;
  logic [axis_w-1:0]        stick_y_cal;
  logic [rtc_w-1:0]         rtc_word;
  logic                     rtc_new;
  logic                     save_download;
  logic                     datatable_wren;
  logic [9:0]               datatable_addr;
  logic [31:0]              datatable_data;

  // expected settings start at zero out of reset
  logic       exp_download = 1'b0;
  logic [3:0] exp_rom_size = '0;
  logic [7:0] exp_rom_type = '0;
  logic [3:0] exp_ram_size = '0;
  logic       exp_pal = 1'b0;
  logic       exp_cpu_turbo = 1'b0;
  logic       exp_gsu_turbo = 1'b0;
  logic       exp_multitap = 1'b0;
  logic [2:0] exp_pointer = '0;
  logic [7:0] exp_aim_speed = '0;
  logic [7:0] exp_deadzone = '0;
  logic       exp_square = 1'b0;
  logic       exp_blend = 1'b0;
  logic [1:0] exp_region = '0;

  int errors = 0;
  int err_base = 0;
  int pass_count = 0;
  int fail_count = 0;
  int cycle_count = 0;

  snes_ctrl_top dut_i (.*);

  initial begin : clock_gen
    clk_74a = 1'b0;
    forever #half_period clk_74a = ~clk_74a;
  end

  initial begin : watchdog
    while (cycle_count < max_cycles) begin
      @(posedge clk_74a);
      cycle_count++;
    end
    $display("timeout, the run did not finish within %0d cycles", max_cycles);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_74a);
    #drive_delay;
  endtask

  task automatic check_val(input string name, input logic [64:0] exp,
                           input logic [64:0] act);
    assert (act === exp) else begin
      $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic start_test();
    err_base = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == err_base) begin
      pass_count++;
      $display("test %s: ok", name);
    end else begin
      fail_count++;
      $display("test %s: FAILED with %0d errors", name, errors - err_base);
    end
  endtask

  // unmapped addresses leave every expected value alone
  task automatic update_expected(input logic [31:0] addr, input logic [31:0] data);
    case (addr)
      addr_download:      exp_download = data[0];
      addr_rom_size:      exp_rom_size = data[3:0];
      addr_rom_type:      exp_rom_type = data[7:0];
      addr_ram_size:      exp_ram_size = data[3:0];
      addr_pal:           exp_pal = data[0];
      addr_cpu_turbo:     exp_cpu_turbo = data[0];
      addr_gsu_turbo:     exp_gsu_turbo = data[0];
      addr_multitap:      exp_multitap = data[0];
      addr_lightgun:      exp_pointer = data[2:0];
      addr_aim_speed:     exp_aim_speed = data[7:0];
      addr_deadzone:      exp_deadzone = data[7:0];
      addr_square_pixels: exp_square = data[0];
      addr_blend:         exp_blend = data[0];
      addr_region:        exp_region = data[1:0];
      default: ;
    endcase
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    next_cycle();
    bridge_wr      = 1'b0;
    update_expected(addr, data);
  endtask

  task automatic compare_settings();
    check_val("ioctl_download", exp_download, ioctl_download);
    check_val("rom_size", exp_rom_size, rom_size);
    check_val("rom_type", exp_rom_type, rom_type);
    check_val("ram_size", exp_ram_size, ram_size);
    check_val("pal", exp_pal, pal);
    check_val("cpu_turbo", exp_cpu_turbo, cpu_turbo);
    check_val("gsu_turbo", exp_gsu_turbo, gsu_turbo);
    check_val("multitap", exp_multitap, multitap);
    check_val("lightgun", exp_pointer[0], lightgun);
    check_val("lightgun_type", exp_pointer[1], lightgun_type);
    check_val("mouse", exp_pointer[2], mouse);
    check_val("dpad_aim_speed", exp_aim_speed, dpad_aim_speed);
    check_val("joystick_deadzone", exp_deadzone, joystick_deadzone);
    check_val("square_pixels", exp_square, square_pixels);
    check_val("blend", exp_blend, blend);
    check_val("core_region", exp_region, core_region);
  endtask

  // PAL flag per region code
  // 01 forces NTSC, 11 forces PAL, 00 and 10 keep the ROM flag
  function automatic logic expected_forced_pal(input logic pal_flag,
                                               input logic [1:0] region);
    case (region)
      2'b01:   return 1'b0;
      2'b11:   return 1'b1;
      default: return pal_flag;
    endcase
  endfunction

  // distance of one axis from center
  function automatic logic [7:0] axis_distance(input logic [7:0] v);
    return v[7] ? {1'b0, v[6:0]} : stick_center - {1'b0, v[6:0]};
  endfunction

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin : main
    logic [31:0] addr_list [16];
    logic [31:0] d;
    logic [7:0]  dz;
    logic [8:0]  dist_sum;
    logic        exp_new;
    logic [31:0] t_prev;
    int          n;

    void'($urandom(32'hc2e26b3c));
    pll_core_locked       = 1'b0;
    bridge_addr           = '0;
    bridge_wr             = 1'b0;
    bridge_wr_data        = '0;
    cont1_joy             = '0;
    rtc_date              = '0;
    rtc_time              = '0;
    dataslot_requestread  = 1'b0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete  = 1'b0;
    sram_size             = '0;
    repeat (10) @(posedge clk_74a);
    #drive_delay;
    pll_core_locked = 1'b1;

    start_test();
    compare_settings();
    check_val("reset_button", 0, reset_button);
    check_val("save_download", 0, save_download);
    check_val("datatable_wren", 0, datatable_wren);
    end_test("reset");

    // two unmapped addresses at the end
    addr_list = '{addr_download, addr_rom_size, addr_rom_type, addr_ram_size, addr_pal,
                  addr_cpu_turbo, addr_gsu_turbo, addr_multitap, addr_lightgun,
                  addr_aim_speed, addr_deadzone, addr_square_pixels, addr_blend,
                  addr_region, 32'h0000_0014, 32'h0000_0300};
    start_test();
    for (int i = 0; i < 16; i++) begin
      bridge_write(addr_list[i], $urandom);
      compare_settings();
    end
    for (int p = 0; p < 2; p++) begin
      for (int r = 0; r < 4; r++) begin
        bridge_write(addr_pal, 32'(p));
        bridge_write(addr_region, 32'(r));
        check_val("forced_pal", expected_forced_pal(p[0], 2'(r)), forced_pal);
      end
    end
    end_test("settings");

    start_test();
    bridge_write(addr_reset, $urandom);
    n = 0;
    while (reset_button === 1'b1 && n < 1000) begin
      n++;
      next_cycle();
    end
    check_val("reset_button high cycles", reset_hold_cycles, n);
    bridge_write(addr_reset, $urandom);
    repeat (100) begin
      next_cycle();
      check_val("reset_button", 1, reset_button);
    end
    // restart the pulse partway through
    bridge_write(addr_reset, $urandom);
    n = 0;
    while (reset_button === 1'b1 && n < 1000) begin
      n++;
      next_cycle();
    end
    check_val("reset_button high cycles", reset_hold_cycles, n);
    end_test("soft_reset");

    start_test();
    for (int i = 0; i < 100; i++) begin
      d = $urandom;
      dist_sum = {1'b0, axis_distance(d[7:0])} + {1'b0, axis_distance(d[15:8])};
      dz = 8'($urandom);
      // every fourth sample sits right on the deadzone edge
      if (i % 4 == 0 && dist_sum < 9'd256) begin
        dz = dist_sum[7:0];
      end
      bridge_write(addr_deadzone, {24'h0, dz});
      cont1_joy = d;
      next_cycle();
      check_val("stick_x_cal", (dist_sum > {1'b0, dz}) ? d[7:0] : stick_center, stick_x_cal);
      check_val("stick_y_cal", (dist_sum > {1'b0, dz}) ? d[15:8] : stick_center, stick_y_cal);
    end
    end_test("deadzone");

    start_test();
    exp_new = 1'b0;
    t_prev  = '0;
    rtc_date = $urandom;
    for (int k = 0; k < 5; k++) begin
      d = $urandom;
      if (d == t_prev) begin
        d = d ^ 32'h1;
      end
      rtc_time = d;
      t_prev   = d;
      exp_new  = ~exp_new;
      next_cycle();
      check_val("rtc_new", exp_new, rtc_new);
      // no further toggles while the time holds
      repeat (3) begin
        next_cycle();
        check_val("rtc_new", exp_new, rtc_new);
      end
      check_val("rtc_word", {exp_new, 8'h00, 8'h01, rtc_date[23:0], rtc_time[23:0]},
                rtc_word);
    end
    end_test("rtc");

    start_test();
    for (int s = 0; s < 6; s++) begin
      sram_size = 4'(s);
      next_cycle();
      check_val("datatable_wren", 1, datatable_wren);
      check_val("datatable_addr", datatable_save_slot, datatable_addr);
      check_val("datatable_data", (s == 0) ? 32'd0 : save_size_unit << s, datatable_data);
    end
    check_val("save_download", 0, save_download);
    dataslot_requestread = 1'b1;
    next_cycle();
    dataslot_requestread = 1'b0;
    check_val("save_download", 1, save_download);
    next_cycle();
    check_val("save_download", 1, save_download);
    dataslot_allcomplete = 1'b1;
    next_cycle();
    check_val("save_download", 0, save_download);
    dataslot_requestwrite = 1'b1;
    next_cycle();
    dataslot_requestwrite = 1'b0;
    check_val("save_download", 1, save_download);
    // allcomplete held high gives no new edge to clear on
    repeat (3) begin
      next_cycle();
      check_val("save_download", 1, save_download);
    end
    dataslot_allcomplete = 1'b0;
    next_cycle();
    check_val("save_download", 1, save_download);
    dataslot_allcomplete = 1'b1;
    next_cycle();
    check_val("save_download", 0, save_download);
    end_test("save_tracking");

    $display("summary: %0d tests ok, %0d tests failing", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog/snes_ctrl_top.sv */
// SNES core control plane top level
// settings decoder, stick calibration, RTC packing and save slot
// tracking side by side on the bridge clock

`timescale 1ns/100ps

module snes_ctrl_top
  import snes_ctrl_pkg::*;
(
  input  logic                     clk_74a,
  input  logic                     pll_core_locked,
  // bridge bus
  input  logic [bridge_addr_w-1:0] bridge_addr,
  input  logic                     bridge_wr,
  input  logic [bridge_data_w-1:0] bridge_wr_data,
  // player 1 sticks, left x and y in the low bytes
  input  logic [31:0]              cont1_joy,
  // host clock and data slot events
  input  logic [31:0]              rtc_date,
  input  logic [31:0]              rtc_time,
  input  logic                     dataslot_requestread,
  input  logic                     dataslot_requestwrite,
  input  logic                     dataslot_allcomplete,
  input  logic [sram_size_w-1:0]   sram_size,
  // core settings
  output logic                     ioctl_download,
  output logic [rom_size_w-1:0]    rom_size,
  output logic [rom_type_w-1:0]    rom_type,
  output logic [ram_size_w-1:0]    ram_size,
  output logic                     pal,
  output logic                     forced_pal,
  output logic                     cpu_turbo,
  output logic                     gsu_turbo,
  output logic                     multitap,
  output logic                     lightgun,
  output logic                     lightgun_type,
  output logic                     mouse,
  output logic [axis_w-1:0]        dpad_aim_speed,
  output logic [axis_w-1:0]        joystick_deadzone,
  output logic                     square_pixels,
  output logic                     blend,
  output logic [region_w-1:0]      core_region,
  output logic                     reset_button,
  // calibrated stick
  output logic [axis_w-1:0]        stick_x_cal,
  output logic [axis_w-1:0]        stick_y_cal,
  // rtc
  output logic [rtc_w-1:0]         rtc_word,
  output logic                     rtc_new,
  // save tracking
  output logic                     save_download,
  output logic                     datatable_wren,
  output logic [9:0]               datatable_addr,
  output logic [31:0]              datatable_data
);

  core_settings_regs settings_i (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .bridge_addr      (bridge_addr),
    .bridge_wr        (bridge_wr),
    .bridge_wr_data   (bridge_wr_data),
    .ioctl_download   (ioctl_download),
    .rom_size         (rom_size),
    .rom_type         (rom_type),
    .ram_size         (ram_size),
    .pal              (pal),
    .forced_pal       (forced_pal),
    .cpu_turbo        (cpu_turbo),
    .gsu_turbo        (gsu_turbo),
    .multitap         (multitap),
    .lightgun         (lightgun),
    .lightgun_type    (lightgun_type),
    .mouse            (mouse),
    .dpad_aim_speed   (dpad_aim_speed),
    .joystick_deadzone(joystick_deadzone),
    .square_pixels    (square_pixels),
    .blend            (blend),
    .core_region      (core_region),
    .reset_button     (reset_button)
  );

  // deadzone comes straight from the settings block
  stick_deadzone stick_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .stick_x        (cont1_joy[7:0]),
    .stick_y        (cont1_joy[15:8]),
    .deadzone       (joystick_deadzone),
    .stick_x_cal    (stick_x_cal),
    .stick_y_cal    (stick_y_cal)
  );

  rtc_packer rtc_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .rtc_date       (rtc_date),
    .rtc_time       (rtc_time),
    .rtc_word       (rtc_word),
    .rtc_new        (rtc_new)
  );

  save_slot_tracker save_i (
    .clk_74a              (clk_74a),
    .pll_core_locked      (pll_core_locked),
    .dataslot_requestread (dataslot_requestread),
    .dataslot_requestwrite(dataslot_requestwrite),
    .dataslot_allcomplete (dataslot_allcomplete),
    .sram_size            (sram_size),
    .save_download        (save_download),
    .datatable_wren       (datatable_wren),
    .datatable_addr       (datatable_addr),
    .datatable_data       (datatable_data)
  );

endmodule

/* verilog/save_slot_tracker.sv */
// Save slot tracker
// holds the save-download flag across a data slot transfer and
// keeps the save size written into the host data table

`timescale 1ns/100ps

module save_slot_tracker
  import snes_ctrl_pkg::*;
(
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,
  input  logic                   dataslot_requestread,
  input  logic                   dataslot_requestwrite,
  input  logic                   dataslot_allcomplete,
  input  logic [sram_size_w-1:0] sram_size,
  output logic                   save_download,
  output logic                   datatable_wren,
  output logic [9:0]             datatable_addr,
  output logic [31:0]            datatable_data
);

  logic allcomplete_prev;
  logic allcomplete_rise;

  assign allcomplete_rise = dataslot_allcomplete && !allcomplete_prev;

  ////////////////////////////////////////
  // save-download flag
  ////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      allcomplete_prev <= 1'b0;
      save_download    <= 1'b0;
    end else begin
      allcomplete_prev <= dataslot_allcomplete;
      // a request wins over completion in the same cycle
      if (dataslot_requestread || dataslot_requestwrite) begin
        save_download <= 1'b1;
      end else if (allcomplete_rise) begin
        save_download <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // data table writer
  ////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable_wren <= 1'b0;
      datatable_addr <= '0;
      datatable_data <= '0;
    end else begin
      datatable_wren <= 1'b1;
      datatable_addr <= datatable_save_slot;
      // size code 0 means no save ram
      datatable_data <= (sram_size != '0) ? (save_size_unit << sram_size) : 32'd0;
    end
  end

endmodule

/* verilog/rtc_packer.sv */
// Real-time clock packer
// flags each change of the host time with a toggle and packs
// date and time into the core's 65 bit RTC word

`timescale 1ns/100ps

module rtc_packer
  import snes_ctrl_pkg::*;
(
  input  logic             clk_74a,
  input  logic             pll_core_locked,
  input  logic [31:0]      rtc_date,
  input  logic [31:0]      rtc_time,
  output logic [rtc_w-1:0] rtc_word,
  output logic             rtc_new
);

  logic [31:0] prev_time;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_time <= '0;
      rtc_new   <= 1'b0;
    end else if (rtc_time != prev_time) begin
      prev_time <= rtc_time;
      rtc_new   <= ~rtc_new;
    end
  end

  // toggle, spare byte, weekday, then bcd date and time bytes
  assign rtc_word = {
    rtc_new,
    8'h00,
    8'h01,
    rtc_date[23:16], rtc_date[15:8], rtc_date[7:0],
    rtc_time[23:16], rtc_time[15:8], rtc_time[7:0]
  };

endmodule

/* verilog/stick_deadzone.sv */
// Analog stick deadzone calibration
// pulls both axes of one stick to center while the stick sits
// inside the deadzone, one cycle of latency

`timescale 1ns/100ps

module stick_deadzone
  import snes_ctrl_pkg::*;
(
  input  logic              clk_74a,
  input  logic              pll_core_locked,
  input  logic [axis_w-1:0] stick_x,
  input  logic [axis_w-1:0] stick_y,
  input  logic [axis_w-1:0] deadzone,
  output logic [axis_w-1:0] stick_x_cal,
  output logic [axis_w-1:0] stick_y_cal
);

  logic [axis_w-1:0] dist_x;
  logic [axis_w-1:0] dist_y;
  logic [axis_w:0]   dist_total;
  logic              outside;

  // distance from center per axis
  assign dist_x = stick_x[axis_w-1] ? {1'b0, stick_x[axis_w-2:0]}
                                    : stick_center - {1'b0, stick_x[axis_w-2:0]};
  assign dist_y = stick_y[axis_w-1] ? {1'b0, stick_y[axis_w-2:0]}
                                    : stick_center - {1'b0, stick_y[axis_w-2:0]};

  // 9 bit sum, no overflow
  assign dist_total = {1'b0, dist_x} + {1'b0, dist_y};

  // equal to the deadzone still counts as inside
  assign outside = dist_total > {1'b0, deadzone};

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      stick_x_cal <= stick_center;
      stick_y_cal <= stick_center;
    end else if (outside) begin
      stick_x_cal <= stick_x;
      stick_y_cal <= stick_y;
    end else begin
      stick_x_cal <= stick_center;
      stick_y_cal <= stick_center;
    end
  end

endmodule

/* verilog/core_settings_regs.sv */
// Core settings registers
// decodes host bridge writes into core settings, runs the timed
// soft-reset pulse and applies the region override to the PAL flag

`timescale 1ns/100ps

module core_settings_regs
  import snes_ctrl_pkg::*;
(
  input  logic                     clk_74a,
  input  logic                     pll_core_locked,
  input  logic [bridge_addr_w-1:0] bridge_addr,
  input  logic                     bridge_wr,
  input  logic [bridge_data_w-1:0] bridge_wr_data,
  output logic                     ioctl_download,
  output logic [rom_size_w-1:0]    rom_size,
  output logic [rom_type_w-1:0]    rom_type,
  output logic [ram_size_w-1:0]    ram_size,
  output logic                     pal,
  output logic                     forced_pal,
  output logic                     cpu_turbo,
  output logic                     gsu_turbo,
  output logic                     multitap,
  output logic                     lightgun,
  output logic                     lightgun_type,
  output logic                     mouse,
  output logic [axis_w-1:0]        dpad_aim_speed,
  output logic [axis_w-1:0]        joystick_deadzone,
  output logic                     square_pixels,
  output logic                     blend,
  output logic [region_w-1:0]      core_region,
  output logic                     reset_button
);

  settings_reg_e sel;
  logic [31:0]   reset_delay;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  always_comb begin
    case (bridge_addr)
      addr_download:      sel = reg_download;
      addr_rom_size:      sel = reg_rom_size;
      addr_rom_type:      sel = reg_rom_type;
      addr_ram_size:      sel = reg_ram_size;
      addr_pal:           sel = reg_pal;
      addr_reset:         sel = reg_reset;
      addr_cpu_turbo:     sel = reg_cpu_turbo;
      addr_gsu_turbo:     sel = reg_gsu_turbo;
      addr_multitap:      sel = reg_multitap;
      addr_lightgun:      sel = reg_lightgun;
      addr_aim_speed:     sel = reg_aim_speed;
      addr_deadzone:      sel = reg_deadzone;
      addr_square_pixels: sel = reg_square_pixels;
      addr_blend:         sel = reg_blend;
      addr_region:        sel = reg_region;
      default:            sel = reg_none;
    endcase
  end

  ////////////////////////////////////////
  // settings and soft-reset counter
  ////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      ioctl_download    <= 1'b0;
      rom_size          <= '0;
      rom_type          <= '0;
      ram_size          <= '0;
      pal               <= 1'b0;
      cpu_turbo         <= 1'b0;
      gsu_turbo         <= 1'b0;
      multitap          <= 1'b0;
      lightgun          <= 1'b0;
      lightgun_type     <= 1'b0;
      mouse             <= 1'b0;
      dpad_aim_speed    <= '0;
      joystick_deadzone <= '0;
      square_pixels     <= 1'b0;
      blend             <= 1'b0;
      core_region       <= '0;
      reset_delay       <= '0;
    end else begin
      // count down the pulse, a fresh reset write reloads it
      if (bridge_wr && sel == reg_reset) begin
        reset_delay <= reset_hold_cycles;
      end else if (reset_delay != 32'd0) begin
        reset_delay <= reset_delay - 32'd1;
      end

      if (bridge_wr) begin
        case (sel)
          reg_download:      ioctl_download    <= bridge_wr_data[0];
          reg_rom_size:      rom_size          <= bridge_wr_data[rom_size_w-1:0];
          reg_rom_type:      rom_type          <= bridge_wr_data[rom_type_w-1:0];
          reg_ram_size:      ram_size          <= bridge_wr_data[ram_size_w-1:0];
          reg_pal:           pal               <= bridge_wr_data[0];
          reg_cpu_turbo:     cpu_turbo         <= bridge_wr_data[0];
          reg_gsu_turbo:     gsu_turbo         <= bridge_wr_data[0];
          reg_multitap:      multitap          <= bridge_wr_data[0];
          reg_lightgun: begin
            // one register carries all three pointer options
            lightgun      <= bridge_wr_data[0];
            lightgun_type <= bridge_wr_data[1];
            mouse         <= bridge_wr_data[2];
          end
          reg_aim_speed:     dpad_aim_speed    <= bridge_wr_data[axis_w-1:0];
          reg_deadzone:      joystick_deadzone <= bridge_wr_data[axis_w-1:0];
          reg_square_pixels: square_pixels     <= bridge_wr_data[0];
          reg_blend:         blend             <= bridge_wr_data[0];
          reg_region:        core_region       <= bridge_wr_data[region_w-1:0];
          default: ;
        endcase
      end
    end
  end

  assign reset_button = (reset_delay != 32'd0);

  // region bit 0 set means bit 1 picks PAL, else use the ROM flag
  assign forced_pal = core_region[0] ? core_region[1] : pal;

endmodule

/* verilog/snes_ctrl_pkg.sv */
// SNES core control plane shared definitions
// bridge register map, field widths, timing constants and the
// register-select type used by the settings decoder

package snes_ctrl_pkg;

  ////////////////////////////////////////
  // bridge bus
  ////////////////////////////////////////

  localparam int bridge_addr_w = 32;
  localparam int bridge_data_w = 32;

  // register map
  localparam logic [31:0] addr_download      = 32'h0000_0000;
  localparam logic [31:0] addr_rom_size      = 32'h0000_0004;
  localparam logic [31:0] addr_rom_type      = 32'h0000_0008;
  localparam logic [31:0] addr_ram_size      = 32'h0000_000C;
  localparam logic [31:0] addr_pal           = 32'h0000_0010;
  localparam logic [31:0] addr_reset         = 32'h0000_0050;
  localparam logic [31:0] addr_cpu_turbo     = 32'h0000_0080;
  localparam logic [31:0] addr_gsu_turbo     = 32'h0000_0084;
  localparam logic [31:0] addr_multitap      = 32'h0000_0100;
  localparam logic [31:0] addr_lightgun      = 32'h0000_0104;
  localparam logic [31:0] addr_aim_speed     = 32'h0000_0108;
  localparam logic [31:0] addr_deadzone      = 32'h0000_010C;
  localparam logic [31:0] addr_square_pixels = 32'h0000_0200;
  localparam logic [31:0] addr_blend         = 32'h0000_0204;
  localparam logic [31:0] addr_region        = 32'h0000_0208;

  // decoded register select, one per mapped address
  typedef enum logic [3:0] {
    reg_none,
    reg_download,
    reg_rom_size,
    reg_rom_type,
    reg_ram_size,
    reg_pal,
    reg_reset,
    reg_cpu_turbo,
    reg_gsu_turbo,
    reg_multitap,
    reg_lightgun,
    reg_aim_speed,
    reg_deadzone,
    reg_square_pixels,
    reg_blend,
    reg_region
  } settings_reg_e;

  ////////////////////////////////////////
  // timing and data constants
  ////////////////////////////////////////

  localparam logic [31:0] reset_hold_cycles   = 32'd256;
  localparam logic [7:0]  stick_center        = 8'd128;
  // slot 1 size word, slot index * 2 + 1
  localparam logic [9:0]  datatable_save_slot = 10'd3;
  localparam logic [31:0] save_size_unit      = 32'd1024;

  // field widths
  localparam int rom_size_w  = 4;
  localparam int ram_size_w  = 4;
  localparam int sram_size_w = 4;
  localparam int rom_type_w  = 8;
  localparam int region_w    = 2;
  localparam int axis_w      = 8;
  localparam int rtc_w       = 65;

endpackage
